// ==== tb.f ====
+incdir+.
rename_pkg.sv
rob_pkg.sv
rename_intf.sv
rat.sv
rob_tracker.sv
rename_top.sv
tb_rename.sv

// ==== Makefile ====
# Verilator build of the rename stage testbench

VERILATOR ?= verilator
TOP       ?= tb_rename
BUILD_DIR ?= build
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal --timescale 1ns/100ps

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f tb.f

# pass or fail comes from the log, not the exit status of the binary
run: compile
	./$(SIM) | tee $(LOG)
	@if grep -q '^\*\* PASS \*\*$$' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== tb_rename.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "rename_consts.svh"

module tb_rename;

    localparam int max_cycles = 4000;
    localparam int n_groups   = 600;

    logic clk;
    logic rst;
    logic flush;
    logic in_valid;
    logic in_ready;
    logic              [`RN_WIDTH-1:0]        in_slot_valid;
    rename_pkg::areg_t [`RN_WIDTH-1:0]        in_dst;
    rename_pkg::areg_t [`RN_WIDTH-1:0]        in_src1;
    rename_pkg::areg_t [`RN_WIDTH-1:0]        in_src2;
    rename_pkg::tag_t  [`RN_WIDTH-1:0]        out_tag;
    logic              [`RN_WIDTH-1:0]        out_src1_valid;
    rename_pkg::tag_t  [`RN_WIDTH-1:0]        out_src1_tag;
    logic              [`RN_WIDTH-1:0]        out_src2_valid;
    rename_pkg::tag_t  [`RN_WIDTH-1:0]        out_src2_tag;
    logic              [`RN_WIDTH-1:0]        out_prev_valid;
    rename_pkg::tag_t  [`RN_WIDTH-1:0]        out_prev_tag;
    logic                                     complete_valid;
    rename_pkg::tag_t                         complete_tag;
    logic              [`RN_RETIRE_PORTS-1:0] retire_valid;
    rename_pkg::areg_t [`RN_RETIRE_PORTS-1:0] retire_dst;
    rename_pkg::tag_t  [`RN_RETIRE_PORTS-1:0] retire_tag;

    // shadow alias table and in-flight tags, oldest first
    rename_pkg::map_table_t shadow;
    rename_pkg::tag_t       inflight[$];
    rename_pkg::areg_t      ent_dst [`RN_ROB_DEPTH];
    logic                   ent_done [`RN_ROB_DEPTH];
    rename_pkg::tag_t       next_tag;
    logic                   warm;

    // expectations for the current cycle, settled at the falling edge
    logic                                       exp_ready;
    rename_pkg::tag_t       [`RN_WIDTH-1:0]        exp_tag;
    rename_pkg::map_entry_t [`RN_WIDTH-1:0]        exp_src1;
    rename_pkg::map_entry_t [`RN_WIDTH-1:0]        exp_src2;
    rename_pkg::map_entry_t [`RN_WIDTH-1:0]        exp_prev;
    logic                   [`RN_RETIRE_PORTS-1:0] exp_ret_valid;
    rename_pkg::areg_t      [`RN_RETIRE_PORTS-1:0] exp_ret_dst;
    rename_pkg::tag_t       [`RN_RETIRE_PORTS-1:0] exp_ret_tag;
    // table after retire clearing, then with the group written
    rename_pkg::map_table_t exp_cleared;
    rename_pkg::map_table_t exp_written;

    logic [31:0] rng;
    logic        took;
    int          accepted;
    int          cycles;
    int          n_rename_err;
    int          n_retire_err;
    int          n_ready_err;

    rename_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic show_mismatch(input string sig, input int idx, input logic [15:0] dut,
                                 input logic [15:0] exp);
        $display("FAILED %0t %s[%0d] dut %h exp %h", $time, sig, idx, dut, exp);
    endtask

    always @(negedge clk) begin
        rename_pkg::tag_t t;
        logic             older;
        exp_ready = warm && !flush && inflight.size() <= `RN_ROB_DEPTH - 2;
        // oldest done entries leave, a port only behind a retiring port
        older = 1'b1;
        for (int j = 0; j < `RN_RETIRE_PORTS; j++) begin
            exp_ret_valid[j] = 1'b0;
            exp_ret_tag[j]   = '0;
            if (inflight.size() > j) begin
                exp_ret_tag[j]   = inflight[j];
                exp_ret_valid[j] = older && ent_done[inflight[j]];
            end
            exp_ret_dst[j] = ent_dst[exp_ret_tag[j]];
            older = exp_ret_valid[j];
        end
        // a later writer keeps its mapping
        exp_cleared = shadow;
        for (int j = 0; j < `RN_RETIRE_PORTS; j++) begin
            if (exp_ret_valid[j] && exp_cleared[exp_ret_dst[j]].valid
                    && exp_cleared[exp_ret_dst[j]].tag == exp_ret_tag[j]) begin
                exp_cleared[exp_ret_dst[j]] = '0;
            end
        end
        // slot 1 looks up after slot 0 has written
        exp_written = exp_cleared;
        t = next_tag;
        for (int i = 0; i < `RN_WIDTH; i++) begin
            exp_tag[i]  = t;
            exp_src1[i] = exp_written[in_src1[i]];
            exp_src2[i] = exp_written[in_src2[i]];
            exp_prev[i] = exp_written[in_dst[i]];
            if (in_slot_valid[i]) begin
                if (in_dst[i] != '0) begin
                    exp_written[in_dst[i]] = '{valid: 1'b1, tag: t};
                end
                t = t + rename_pkg::tag_t'(1);
            end
        end
    end

    task automatic update_model();
        took = 1'b0;
        if (rst || flush) begin
            shadow   = '0;
            next_tag = '0;
            warm     = 1'b0;
            inflight.delete();
            for (int k = 0; k < `RN_ROB_DEPTH; k++) begin
                ent_done[k] = 1'b0;
            end
        end else begin
            warm = 1'b1;
            for (int j = 0; j < `RN_RETIRE_PORTS; j++) begin
                if (exp_ret_valid[j]) begin
                    void'(inflight.pop_front());
                end
            end
            if (complete_valid) begin
                ent_done[complete_tag] = 1'b1;
            end
            shadow = exp_cleared;
            if (in_valid && exp_ready) begin
                took   = 1'b1;
                shadow = exp_written;
                accepted++;
                for (int i = 0; i < `RN_WIDTH; i++) begin
                    if (in_slot_valid[i]) begin
                        inflight.push_back(exp_tag[i]);
                        ent_dst[exp_tag[i]]  = in_dst[i];
                        ent_done[exp_tag[i]] = 1'b0;
                        next_tag = exp_tag[i] + rename_pkg::tag_t'(1);
                    end
                end
            end
        end
    endtask

    task automatic tick();
        @(posedge clk);
        update_model();
    endtask

    task automatic drive_group();
        logic [31:0] r;
        // source holds a group that was not taken
        if (!(in_valid && !took)) begin
            rng = xorshift(rng);
            in_valid <= rng[0] | rng[1];
            for (int i = 0; i < `RN_WIDTH; i++) begin
                rng = xorshift(rng);
                r   = rng;
                in_slot_valid[i] <= r[2:0] != 3'd0;
                // mostly low registers, so groups depend on each other
                in_dst[i]  <= r[3] ? r[8:4] : {2'b00, r[6:4]};
                in_src1[i] <= r[9] ? r[14:10] : {2'b00, r[12:10]};
                in_src2[i] <= r[15] ? r[20:16] : {2'b00, r[18:16]};
            end
        end
    endtask

    task automatic drive_completion();
        rename_pkg::tag_t busy[$];
        foreach (inflight[k]) begin
            if (!ent_done[inflight[k]]) begin
                busy.push_back(inflight[k]);
            end
        end
        rng = xorshift(rng);
        // random pick among busy entries, so completions come out of order
        complete_valid <= busy.size() > 0 && rng[2:0] != 3'd0;
        complete_tag   <= busy.size() > 0 ? busy[rng[31:8] % busy.size()] : '0;
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: retirement did not drain within %0d cycles", max_cycles);
            $display("errors: rename %0d, retire %0d, ready %0d",
                     n_rename_err, n_retire_err, n_ready_err);
            $display("** FAIL **");
            $finish;
        end
    end

    a_ready: assert property (@(posedge clk) disable iff (rst) in_ready == exp_ready)
        else begin
            n_ready_err++;
            show_mismatch("in_ready", 0, $sampled(in_ready), $sampled(exp_ready));
        end

    for (genvar i = 0; i < `RN_WIDTH; i++) begin : g_slot_chk
        a_tag: assert property (@(posedge clk) disable iff (rst)
            !in_slot_valid[i] || out_tag[i] == exp_tag[i])
            else begin
                n_rename_err++;
                show_mismatch("out_tag", i, $sampled(out_tag[i]), $sampled(exp_tag[i]));
            end
        a_src1: assert property (@(posedge clk) disable iff (rst)
            out_src1_valid[i] == exp_src1[i].valid
            && (!exp_src1[i].valid || out_src1_tag[i] == exp_src1[i].tag))
            else begin
                n_rename_err++;
                show_mismatch("out_src1", i, $sampled({out_src1_valid[i], out_src1_tag[i]}),
                              $sampled(exp_src1[i]));
            end
        a_src2: assert property (@(posedge clk) disable iff (rst)
            out_src2_valid[i] == exp_src2[i].valid
            && (!exp_src2[i].valid || out_src2_tag[i] == exp_src2[i].tag))
            else begin
                n_rename_err++;
                show_mismatch("out_src2", i, $sampled({out_src2_valid[i], out_src2_tag[i]}),
                              $sampled(exp_src2[i]));
            end
        a_prev: assert property (@(posedge clk) disable iff (rst)
            out_prev_valid[i] == exp_prev[i].valid
            && (!exp_prev[i].valid || out_prev_tag[i] == exp_prev[i].tag))
            else begin
                n_rename_err++;
                show_mismatch("out_prev", i, $sampled({out_prev_valid[i], out_prev_tag[i]}),
                              $sampled(exp_prev[i]));
            end
    end

    for (genvar j = 0; j < `RN_RETIRE_PORTS; j++) begin : g_ret_chk
        a_retire: assert property (@(posedge clk) disable iff (rst)
            retire_valid[j] == exp_ret_valid[j] && (!exp_ret_valid[j]
            || {retire_dst[j], retire_tag[j]} == {exp_ret_dst[j], exp_ret_tag[j]}))
            else begin
                n_retire_err++;
                show_mismatch("retire", j,
                              $sampled({retire_valid[j], retire_dst[j], retire_tag[j]}),
                              $sampled({exp_ret_valid[j], exp_ret_dst[j], exp_ret_tag[j]}));
            end
    end

    initial begin
        rst            = 1'b1;
        flush          = 1'b0;
        in_valid       = 1'b0;
        in_slot_valid  = '0;
        in_dst         = '0;
        in_src1        = '0;
        in_src2        = '0;
        complete_valid = 1'b0;
        complete_tag   = '0;
        rng            = 32'h8007_4b37;
        accepted       = 0;
        cycles         = 0;
        n_rename_err   = 0;
        n_retire_err   = 0;
        n_ready_err    = 0;
        for (int k = 0; k < `RN_ROB_DEPTH; k++) begin
            ent_dst[k] = '0;
        end
        repeat (16) tick();
        rst <= 1'b0;
        while (accepted < n_groups) begin
            tick();
            drive_group();
            drive_completion();
            // mid-stream flush every 200 groups
            flush <= took && accepted % 200 == 0 && accepted < n_groups;
        end
        in_valid <= 1'b0;
        flush    <= 1'b0;
        // drain until every allocated entry has retired
        while (inflight.size() != 0) begin
            tick();
            drive_completion();
        end
        repeat (2) tick();
        $display("errors: rename %0d, retire %0d, ready %0d",
                 n_rename_err, n_retire_err, n_ready_err);
        if (n_rename_err + n_retire_err + n_ready_err == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rename_top.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "rename_consts.svh"

// rename stage, two wide
module rename_top (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     flush,
    // group handshake
    input  logic                                     in_valid,
    output logic                                     in_ready,
    input  logic              [`RN_WIDTH-1:0]        in_slot_valid,
    input  rename_pkg::areg_t [`RN_WIDTH-1:0]        in_dst,
    input  rename_pkg::areg_t [`RN_WIDTH-1:0]        in_src1,
    input  rename_pkg::areg_t [`RN_WIDTH-1:0]        in_src2,
    // rename results, same cycle as the group
    output rename_pkg::tag_t  [`RN_WIDTH-1:0]        out_tag,
    output logic              [`RN_WIDTH-1:0]        out_src1_valid,
    output rename_pkg::tag_t  [`RN_WIDTH-1:0]        out_src1_tag,
    output logic              [`RN_WIDTH-1:0]        out_src2_valid,
    output rename_pkg::tag_t  [`RN_WIDTH-1:0]        out_src2_tag,
    output logic              [`RN_WIDTH-1:0]        out_prev_valid,
    output rename_pkg::tag_t  [`RN_WIDTH-1:0]        out_prev_tag,
    // completion, always taken
    input  logic                                     complete_valid,
    input  rename_pkg::tag_t                         complete_tag,
    // retirement, no back-pressure
    output logic              [`RN_RETIRE_PORTS-1:0] retire_valid,
    output rename_pkg::areg_t [`RN_RETIRE_PORTS-1:0] retire_dst,
    output rename_pkg::tag_t  [`RN_RETIRE_PORTS-1:0] retire_tag
);

    renaming_intf ren_if ();
    retire_intf   ret_if ();

    logic accept;

    assign accept = in_valid && in_ready;

    for (genvar i = 0; i < `RN_WIDTH; i++) begin : g_slot
        assign ren_if.instr[i] = '{valid: in_slot_valid[i], dst: in_dst[i],
                                   src1: in_src1[i], src2: in_src2[i]};
        assign out_tag[i]        = ren_if.rob_addr_new[i];
        assign out_src1_valid[i] = ren_if.renaming_info[i].src1.valid;
        assign out_src1_tag[i]   = ren_if.renaming_info[i].src1.tag;
        assign out_src2_valid[i] = ren_if.renaming_info[i].src2.valid;
        assign out_src2_tag[i]   = ren_if.renaming_info[i].src2.tag;
        assign out_prev_valid[i] = ren_if.renaming_info[i].prev.valid;
        assign out_prev_tag[i]   = ren_if.renaming_info[i].prev.tag;
    end

    for (genvar j = 0; j < `RN_RETIRE_PORTS; j++) begin : g_ret
        assign retire_valid[j] = ret_if.retire[j].valid;
        assign retire_dst[j]   = ret_if.retire[j].dst;
        assign retire_tag[j]   = ret_if.retire[j].tag;
    end

    rat u_rat (
        .clk      (clk),
        .rst      (rst),
        .flush    (flush),
        .renaming (ren_if.rat),
        .retire   (ret_if.rat),
        .accept   (accept)
    );

    rob_tracker u_rob (
        .clk            (clk),
        .rst            (rst),
        .flush          (flush),
        .accept         (accept),
        .ready          (in_ready),
        .renaming       (ren_if.alloc),
        .complete_valid (complete_valid),
        .complete_tag   (complete_tag),
        .retire         (ret_if.rob)
    );

endmodule

`default_nettype wire

// ==== rob_tracker.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "rename_consts.svh"

// reorder buffer bookkeeping, no data
module rob_tracker (
    input  logic             clk,
    input  logic             rst,
    input  logic             flush,
    input  logic             accept,
    output logic             ready,
    renaming_intf.alloc      renaming,
    input  logic             complete_valid,
    input  rename_pkg::tag_t complete_tag,
    retire_intf.rob          retire
);

    // occupancy needs one more bit than a tag
    typedef logic [`RN_TAG_BITS:0] cnt_t;

    localparam cnt_t rob_depth = cnt_t'(`RN_ROB_DEPTH);
    // room for a full group
    localparam cnt_t max_fill  = cnt_t'(`RN_ROB_DEPTH - `RN_WIDTH);

    rob_pkg::rob_entry_t entries [`RN_ROB_DEPTH];

    rename_pkg::tag_t head;
    rename_pkg::tag_t tail;
    cnt_t             count;
    // low for the first cycle after reset or flush
    logic             warm;

    rename_pkg::tag_t [`RN_WIDTH-1:0] alloc_tag;
    rename_pkg::tag_t                 alloc_offs;
    rename_pkg::tag_t                 n_alloc;

    rob_pkg::retire_t [`RN_RETIRE_PORTS-1:0] ret;
    rename_pkg::tag_t                        ret_tag;
    logic                                    ret_ok;
    rename_pkg::tag_t                        n_ret;

    // consecutive tags for valid slots, from the tail
    always_comb begin
        alloc_offs = '0;
        for (int i = 0; i < `RN_WIDTH; i++) begin
            alloc_tag[i] = tail + alloc_offs;
            if (renaming.instr[i].valid) begin
                alloc_offs = alloc_offs + 1'b1;
            end
        end
        n_alloc = accept ? alloc_offs : '0;
    end

    assign renaming.rob_addr_new = alloc_tag;

    // in-order retire from the head, a port needs all older ports retiring
    always_comb begin
        ret_ok  = 1'b1;
        ret_tag = head;
        n_ret   = '0;
        for (int j = 0; j < `RN_RETIRE_PORTS; j++) begin
            ret[j].valid = ret_ok && entries[ret_tag].state == rob_pkg::ROB_DONE;
            ret[j].dst   = entries[ret_tag].dst;
            ret[j].tag   = ret_tag;
            if (ret[j].valid) begin
                n_ret = n_ret + 1'b1;
            end
            ret_ok  = ret[j].valid;
            ret_tag = ret_tag + 1'b1;
        end
    end

    assign retire.retire = ret;

    // state only, never looks at in_valid
    assign ready = warm && !flush && count <= max_fill;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            warm  <= 1'b0;
            for (int k = 0; k < `RN_ROB_DEPTH; k++) begin
                entries[k].state <= rob_pkg::ROB_FREE;
            end
        end else begin
            warm  <= 1'b1;
            head  <= head + n_ret;
            tail  <= tail + n_alloc;
            count <= count + cnt_t'(n_alloc) - cnt_t'(n_ret);
            // retired, completed and allocated entries never overlap
            for (int j = 0; j < `RN_RETIRE_PORTS; j++) begin
                if (ret[j].valid) begin
                    entries[ret[j].tag].state <= rob_pkg::ROB_FREE;
                end
            end
            if (complete_valid) begin
                entries[complete_tag].state <= rob_pkg::ROB_DONE;
            end
            for (int i = 0; i < `RN_WIDTH; i++) begin
                if (accept && renaming.instr[i].valid) begin
                    entries[alloc_tag[i]].state <= rob_pkg::ROB_BUSY;
                    entries[alloc_tag[i]].dst   <= renaming.instr[i].dst;
                end
            end
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (rst) count <= rob_depth)
        else $error("rob_tracker: count above depth");

    // reporter outside must only complete in-flight work
    a_complete_busy: assert property (@(posedge clk) disable iff (rst || flush)
        complete_valid |-> entries[complete_tag].state == rob_pkg::ROB_BUSY)
        else $error("rob_tracker: completion of non-busy tag %0d", complete_tag);

    // a retiring port lies inside the occupied window
    for (genvar j = 0; j < `RN_RETIRE_PORTS; j++) begin : g_ret_chk
        a_retire_live: assert property (@(posedge clk) disable iff (rst)
            retire.retire[j].valid |-> count > cnt_t'(j))
            else $error("rob_tracker: retire port %0d names a free entry", j);
    end

endmodule

`default_nettype wire

// ==== rat.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "rename_consts.svh"

// register alias table
module rat (
    input  logic      clk,
    input  logic      rst,
    input  logic      flush,
    renaming_intf.rat renaming,
    retire_intf.rat   retire,
    input  logic      accept
);

    // committed table
    rename_pkg::map_table_t map_table;
    // after retire clearing only
    rename_pkg::map_table_t map_cleared;
    // after retire clearing and group writes
    rename_pkg::map_table_t map_work;
    rename_pkg::map_table_t map_table_nxt;

    rename_pkg::rn_info_t [`RN_WIDTH-1:0] info;

    always_comb begin
        map_work = map_table;
        // retire first
        // only clear if the mapping still points at the retiring tag
        for (int j = 0; j < `RN_RETIRE_PORTS; j++) begin
            if (retire.retire[j].valid && map_work[retire.retire[j].dst].valid
                    && map_work[retire.retire[j].dst].tag == retire.retire[j].tag) begin
                map_work[retire.retire[j].dst] = '0;
            end
        end
        map_cleared = map_work;
        // then slots in program order
        // lookups see earlier slots of the same group
        for (int i = 0; i < `RN_WIDTH; i++) begin
            info[i].src1 = map_work[renaming.instr[i].src1];
            info[i].src2 = map_work[renaming.instr[i].src2];
            // mapping this slot overwrites
            info[i].prev = map_work[renaming.instr[i].dst];
            // r0 is hardwired, never mapped
            if (renaming.instr[i].valid && renaming.instr[i].dst != '0) begin
                map_work[renaming.instr[i].dst].valid = 1'b1;
                map_work[renaming.instr[i].dst].tag   = renaming.rob_addr_new[i];
            end
        end
    end

    // group writes land only on an accepting edge
    assign map_table_nxt = accept ? map_work : map_cleared;

    assign renaming.renaming_info = info;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            map_table <= '0;
        end else begin
            map_table <= map_table_nxt;
        end
    end

    // a new tag comes from a free entry, so no mapping may still hold it
    for (genvar i = 0; i < `RN_WIDTH; i++) begin : g_chk
        a_tag_fresh: assert property (@(posedge clk) disable iff (rst || flush)
            accept && renaming.instr[i].valid
            |-> !(info[i].prev.valid && info[i].prev.tag == renaming.rob_addr_new[i]))
            else $error("rat: slot %0d new tag %0d still mapped", i,
                        renaming.rob_addr_new[i]);
    end

endmodule

`default_nettype wire

// ==== rename_intf.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "rename_consts.svh"

// rename group between the stage, the tracker and the alias table
interface renaming_intf;

    // group as presented by the stage
    rename_pkg::rn_instr_t [`RN_WIDTH-1:0] instr;
    // tags offered by the tracker, in slot order
    rename_pkg::tag_t      [`RN_WIDTH-1:0] rob_addr_new;
    // lookup results from the table
    rename_pkg::rn_info_t  [`RN_WIDTH-1:0] renaming_info;

    // tracker side
    modport alloc (input instr, output rob_addr_new);

    // table side
    modport rat (input instr, input rob_addr_new, output renaming_info);

    // stage side
    modport stage (output instr, input rob_addr_new, input renaming_info);

endinterface

// retirements from the tracker back to the table
interface retire_intf;

    // port 0 is always the oldest
    rob_pkg::retire_t [`RN_RETIRE_PORTS-1:0] retire;

    modport rob (output retire);

    modport rat (input retire);

endinterface

`default_nettype wire

// ==== rob_pkg.sv ====
`default_nettype none

package rob_pkg;

    // entry life cycle
    typedef enum logic [1:0] {
        ROB_FREE,
        ROB_BUSY,
        ROB_DONE
    } rob_state_e;

    // tracked per entry, no data values here
    typedef struct packed {
        rob_state_e          state;
        rename_pkg::areg_t   dst;
    } rob_entry_t;

    // one retirement, tag is the entry index
    typedef struct packed {
        logic              valid;
        rename_pkg::areg_t dst;
        rename_pkg::tag_t  tag;
    } retire_t;

endpackage

`default_nettype wire

// ==== rename_pkg.sv ====
`default_nettype none
`include "rename_consts.svh"

package rename_pkg;

    // architectural register index
    typedef logic [`RN_AREG_BITS-1:0] areg_t;

    // reorder buffer tag
    typedef logic [`RN_TAG_BITS-1:0] tag_t;

    // one slot of an incoming group
    typedef struct packed {
        logic  valid;
        areg_t dst;
        areg_t src1;
        areg_t src2;
    } rn_instr_t;

    // alias table entry, valid means an in-flight producer exists
    typedef struct packed {
        logic valid;
        tag_t tag;
    } map_entry_t;

    // source lookup, not valid reads the register file
    typedef map_entry_t src_info_t;

    // per-slot rename result
    typedef struct packed {
        src_info_t  src1;
        src_info_t  src2;
        map_entry_t prev;
    } rn_info_t;

    typedef map_entry_t [`RN_AREGS-1:0] map_table_t;

endpackage

`default_nettype wire

// ==== rename_consts.svh ====
`ifndef RENAME_CONSTS_SVH
`define RENAME_CONSTS_SVH

// instructions renamed per group
`define RN_WIDTH 2

// architectural register file
`define RN_AREGS 32
`define RN_AREG_BITS 5

// reorder buffer size, tag is a plain index into it
`define RN_ROB_DEPTH 16
`define RN_TAG_BITS 4

// max entries retired per cycle
`define RN_RETIRE_PORTS 2

`endif
